/* Bender.yml */
package:
  name: iigs_glue

export_include_dirs:
  - common

sources:
  - common/iigs_pkg.sv
  - rtl/bus_map.sv
  - soft_switches/soft_switches.sv
  - rtl/irq_ctrl.sv
  - rtl/mem_select.sv
  - rtl/iigs_glue.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/tb_iigs_glue.sv

/* common/iigs_macros.svh */
`ifndef IIGS_MACROS_SVH
`define IIGS_MACROS_SVH

// fast ram banks 00 up to 13
`define IIGS_RAM_BANKS 8'd20

`define IIGS_BANK_MAIN0 8'h00
`define IIGS_BANK_MAIN1 8'h01
`define IIGS_BANK_SLOW0 8'hE0
`define IIGS_BANK_SLOW1 8'hE1
`define IIGS_BANK_ROMC 8'hFC
`define IIGS_BANK_ROMD 8'hFD
`define IIGS_BANK_ROM1 8'hFE
`define IIGS_BANK_ROM2 8'hFF

`define IIGS_IO_PAGE 8'hC0
// first slot register, C090
`define IIGS_IO_SLOT_BASE 8'h90

`define IIGS_LC_BASE 16'hD000
`define IIGS_LC_TOP 16'hDFFF
`define IIGS_ROM_BASE 16'hC000

// shadowed video regions in banks 00/01
`define IIGS_TXT1_BASE 16'h0400
`define IIGS_TXT1_TOP 16'h07FF
`define IIGS_TXT2_BASE 16'h0800
`define IIGS_TXT2_TOP 16'h0BFF
`define IIGS_HGR1_BASE 16'h2000
`define IIGS_HGR1_TOP 16'h3FFF
`define IIGS_HGR2_BASE 16'h4000
`define IIGS_HGR2_TOP 16'h5FFF

// register offsets inside the C0 page
`define IIGS_OFS_TEXTCOLOR 8'h22
`define IIGS_OFS_VGCINT 8'h23
`define IIGS_OFS_NEWVIDEO 8'h29
`define IIGS_OFS_SLTROMSEL 8'h2D
`define IIGS_OFS_VGCINTCLR 8'h32
`define IIGS_OFS_BORDER 8'h34
`define IIGS_OFS_SHADOW 8'h35
`define IIGS_OFS_INTEN 8'h41
`define IIGS_OFS_INTFLAG 8'h46
`define IIGS_OFS_INTCLR 8'h47
`define IIGS_OFS_STATEREG 8'h68

`define IIGS_RST_SHADOW 8'h08
`define IIGS_RST_NEWVIDEO 8'h41
`define IIGS_RST_TEXTCOLOR 8'hF2

`endif

/* common/iigs_pkg.sv */
package iigs_pkg;

  // data byte on the processor and memory buses
  typedef logic [7:0] byte_t;

  // 64k bank number
  typedef logic [7:0] bank_t;

  // address inside one bank
  typedef logic [15:0] offset_t;

  // full 24-bit processor address, bank in the upper byte
  typedef struct packed {
    bank_t   bank;
    offset_t offset;
  } cpu_addr_t;

endpackage

/* compile.f */
+incdir+common
common/iigs_pkg.sv
rtl/bus_map.sv
soft_switches/soft_switches.sv
rtl/irq_ctrl.sv
rtl/mem_select.sv
rtl/iigs_glue.sv
tests/tb_clock.sv
tests/tb_iigs_glue.sv

/* rtl/bus_map.sv */
`timescale 1ns/1ps
`include "iigs_macros.svh"

module bus_map import iigs_pkg::*; (
  input  cpu_addr_t cpu_addr,
  input  logic      cpu_we,
  input  logic      alt_zp,
  input  logic      store80,
  input  logic      page2,
  input  logic      hires_mode,
  input  logic      ram_rd,
  input  logic      ram_wrt,
  input  logic      rd_rom,
  input  logic      lc_ram2,
  input  byte_t     shadow,
  input  byte_t     slot_rom_sel,
  output bank_t     bank,
  output offset_t   addr,
  output logic      io,
  output logic      inhibit_cxxx
);

  bank_t   cpu_bank;
  offset_t cpu_ofs;
  logic    bank_main;
  logic    bank_slow;
  logic    bank_aux_capable;
  logic    rw_aux;
  logic    aux_sel;
  logic    aux;
  logic    lc_window;
  logic    lcram2_sel;
  logic    slot_io;

  assign cpu_bank = cpu_addr.bank;
  assign cpu_ofs  = cpu_addr.offset;

  assign bank_main = (cpu_bank == `IIGS_BANK_MAIN0) || (cpu_bank == `IIGS_BANK_MAIN1);
  assign bank_slow = (cpu_bank == `IIGS_BANK_SLOW0) || (cpu_bank == `IIGS_BANK_SLOW1);

  // only the even banks have an auxiliary partner above them
  assign bank_aux_capable = (cpu_bank == `IIGS_BANK_MAIN0) ||
                            (cpu_bank == `IIGS_BANK_SLOW0);

  // ramrd steers reads, ramwrt steers writes
  assign rw_aux = cpu_we ? ram_wrt : ram_rd;

  always_comb begin
    if (cpu_ofs[15:9] == 7'd0 || cpu_ofs[15:14] == 2'b11) begin
      // zero page, stack and the language card area
      aux_sel = alt_zp;
    end else if (cpu_ofs[15:10] == 6'b000001) begin
      // text page 1, 80STORE hands it to PAGE2
      aux_sel = store80 ? page2 : rw_aux;
    end else if (cpu_ofs[15:13] == 3'b001) begin
      // hi-res page 1 follows PAGE2 only in hi-res mode
      aux_sel = (store80 && hires_mode) ? page2 : rw_aux;
    end else begin
      aux_sel = rw_aux;
    end
  end

  assign aux = bank_aux_capable && aux_sel;

  assign lc_window = (cpu_ofs >= `IIGS_LC_BASE) && (cpu_ofs <= `IIGS_LC_TOP);

  // bank 2 of the language card lives at C000-CFFF of the same bank
  assign lcram2_sel = lc_window && lc_ram2 &&
                      ((bank_slow && rd_rom) || (bank_main && !shadow[6]));

  assign bank = cpu_bank + bank_t'(aux);
  assign addr = lcram2_sel ? (cpu_ofs - offset_t'(16'h1000)) : cpu_ofs;

  // C090-C0FF belongs to a slot card when its SLTROMSEL bit is set
  assign slot_io = (cpu_ofs[7:0] >= `IIGS_IO_SLOT_BASE) && slot_rom_sel[cpu_ofs[6:4]];

  assign io = (bank_main || bank_slow) && !shadow[6] &&
              (cpu_ofs[15:8] == `IIGS_IO_PAGE) && !slot_io;

  assign inhibit_cxxx = lcram2_sel || (bank_main && shadow[6]);

endmodule

/* rtl/iigs_glue.sv */
`timescale 1ns/1ps

module iigs_glue import iigs_pkg::*; (
  input  logic      clk_sys,
  input  logic      cpu_vda,
  input  cpu_addr_t cpu_addr,
  input  byte_t     cpu_dout,
  input  logic      cpu_we,
  input  logic      cpu_ce,
  input  logic      cpu_vpb,
  input  byte_t     din,
  input  logic      scanline_irq,
  input  logic      vbl_irq,
  input  logic      onesecond_irq,
  input  logic      qtrsecond_irq,
  output bank_t     bank,
  output offset_t   addr,
  output byte_t     cpu_din,
  output logic      io,
  output logic      inhibit_cxxx,
  output logic      slowram_ce,
  output logic      fastram_ce,
  output logic      rom1_ce,
  output logic      rom2_ce,
  output logic      romc_ce,
  output logic      romd_ce,
  output logic      irq_n,
  output byte_t     shadow,
  output byte_t     text_color,
  output logic [3:0] border_color,
  output byte_t     new_video,
  output byte_t     slot_rom_sel,
  output logic      text_g,
  output logic      mix_g,
  output logic      page2,
  output logic      hires_mode,
  output logic      alt_charset,
  output logic      eighty_col,
  output logic      int_cx_rom,
  output logic      rd_rom,
  output logic      lc_ram2,
  output logic      lc_we
);

  // memory mapping switches that stay inside the glue
  logic  alt_zp;
  logic  store80;
  logic  ram_rd;
  logic  ram_wrt;
  byte_t io_dout;

  // interrupt register traffic
  logic  vgc_en_wr;
  logic  vgc_clr_wr;
  logic  inten_wr;
  logic  int_clr;
  byte_t vgc_int;
  byte_t int_en;
  byte_t int_flag;

  bus_map bus_map_inst (
    .cpu_addr(cpu_addr), .cpu_we(cpu_we),
    .alt_zp(alt_zp), .store80(store80), .page2(page2), .hires_mode(hires_mode),
    .ram_rd(ram_rd), .ram_wrt(ram_wrt), .rd_rom(rd_rom), .lc_ram2(lc_ram2),
    .shadow(shadow), .slot_rom_sel(slot_rom_sel),
    .bank(bank), .addr(addr), .io(io), .inhibit_cxxx(inhibit_cxxx)
  );

  soft_switches soft_switches_inst (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .cpu_ce(cpu_ce), .cpu_we(cpu_we),
    .io(io), .addr(addr), .cpu_dout(cpu_dout),
    .vgc_int(vgc_int), .int_en(int_en), .int_flag(int_flag),
    .io_dout(io_dout), .shadow(shadow), .text_color(text_color),
    .border_color(border_color), .new_video(new_video), .slot_rom_sel(slot_rom_sel),
    .text_g(text_g), .mix_g(mix_g), .page2(page2), .hires_mode(hires_mode),
    .alt_charset(alt_charset), .eighty_col(eighty_col), .int_cx_rom(int_cx_rom),
    .rd_rom(rd_rom), .lc_ram2(lc_ram2), .lc_we(lc_we),
    .alt_zp(alt_zp), .store80(store80), .ram_rd(ram_rd), .ram_wrt(ram_wrt),
    .vgc_en_wr(vgc_en_wr), .vgc_clr_wr(vgc_clr_wr), .inten_wr(inten_wr),
    .int_clr(int_clr)
  );

  irq_ctrl irq_ctrl_inst (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .cpu_dout(cpu_dout),
    .vgc_en_wr(vgc_en_wr), .vgc_clr_wr(vgc_clr_wr), .inten_wr(inten_wr),
    .int_clr(int_clr), .scanline_irq(scanline_irq), .vbl_irq(vbl_irq),
    .onesecond_irq(onesecond_irq), .qtrsecond_irq(qtrsecond_irq),
    .vgc_int(vgc_int), .int_en(int_en), .int_flag(int_flag), .irq_n(irq_n)
  );

  mem_select mem_select_inst (
    .bank(bank), .addr(addr), .cpu_addr(cpu_addr), .io(io), .shadow(shadow),
    .rd_rom(rd_rom), .lc_we(lc_we), .cpu_vpb(cpu_vpb), .io_dout(io_dout), .din(din),
    .slowram_ce(slowram_ce), .fastram_ce(fastram_ce), .rom1_ce(rom1_ce),
    .rom2_ce(rom2_ce), .romc_ce(romc_ce), .romd_ce(romd_ce), .cpu_din(cpu_din)
  );

endmodule

/* rtl/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl import iigs_pkg::*; (
  input  logic  clk_sys,
  input  logic  cpu_vda,
  input  byte_t cpu_dout,
  input  logic  vgc_en_wr,
  input  logic  vgc_clr_wr,
  input  logic  inten_wr,
  input  logic  int_clr,
  input  logic  scanline_irq,
  input  logic  vbl_irq,
  input  logic  onesecond_irq,
  input  logic  qtrsecond_irq,
  output byte_t vgc_int,
  output byte_t int_en,
  output byte_t int_flag,
  output logic  irq_n
);

  logic pending;

  // vgc_int: 7 any, 6 second, 5 scanline, 2/1 their enables
  // int_flag: 4 quarter second, 3 vbl, 0 system irq
  assign pending = int_flag[3] | int_flag[4] | vgc_int[6] | vgc_int[7];

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      vgc_int  <= 8'h00;
      int_en   <= 8'h00;
      int_flag <= 8'h00;
    end else begin
      if (vgc_en_wr) begin
        vgc_int[2:1] <= cpu_dout[2:1];
      end
      if (vgc_clr_wr) begin
        // a 0 in the data clears the matching status bit
        if (!cpu_dout[6]) vgc_int[6] <= 1'b0;
        if (!cpu_dout[5]) vgc_int[5] <= 1'b0;
        if (!(vgc_int[6] && cpu_dout[6]) && !(vgc_int[5] && cpu_dout[5])) begin
          vgc_int[7] <= 1'b0;
        end
      end
      if (scanline_irq) begin
        // status is set even with the enable off
        vgc_int[5] <= 1'b1;
        if (vgc_int[1]) vgc_int[7] <= 1'b1;
      end
      if (onesecond_irq && vgc_int[2]) begin
        vgc_int[6] <= 1'b1;
        vgc_int[7] <= 1'b1;
      end

      if (inten_wr) begin
        int_en[4:0] <= cpu_dout[4:0];
      end
      int_flag[0] <= pending;
      if (vbl_irq && int_en[3]) int_flag[3] <= 1'b1;
      if (qtrsecond_irq && int_en[4]) int_flag[4] <= 1'b1;
      if (int_clr) begin
        int_flag[4:3] <= 2'b00;
        int_flag[0]   <= 1'b0;
      end
    end
  end

  assign irq_n = !((vgc_int[6] & vgc_int[2]) | (vgc_int[5] & vgc_int[1]) |
                   (int_flag[3] & int_en[3]) | (int_flag[4] & int_en[4]));

endmodule

/* rtl/mem_select.sv */
`timescale 1ns/1ps
`include "iigs_macros.svh"

module mem_select import iigs_pkg::*; (
  input  bank_t     bank,
  input  offset_t   addr,
  input  cpu_addr_t cpu_addr,
  input  logic      io,
  input  byte_t     shadow,
  input  logic      rd_rom,
  input  logic      lc_we,
  input  logic      cpu_vpb,
  input  byte_t     io_dout,
  input  byte_t     din,
  output logic      slowram_ce,
  output logic      fastram_ce,
  output logic      rom1_ce,
  output logic      rom2_ce,
  output logic      romc_ce,
  output logic      romd_ce,
  output byte_t     cpu_din
);

  logic b0;
  logic b1;
  logic txt1;
  logic txt2;
  logic hgr1;
  logic hgr2;
  logic hi_area;
  logic shadowed;
  logic rom_writethrough;

  assign b0 = (bank == `IIGS_BANK_MAIN0);
  assign b1 = (bank == `IIGS_BANK_MAIN1);

  assign txt1    = (addr >= `IIGS_TXT1_BASE) && (addr <= `IIGS_TXT1_TOP);
  assign txt2    = (addr >= `IIGS_TXT2_BASE) && (addr <= `IIGS_TXT2_TOP);
  assign hgr1    = (addr >= `IIGS_HGR1_BASE) && (addr <= `IIGS_HGR1_TOP);
  assign hgr2    = (addr >= `IIGS_HGR2_BASE) && (addr <= `IIGS_HGR2_TOP);
  assign hi_area = (addr >= `IIGS_ROM_BASE);

  // a set shadow bit inhibits shadowing of that region
  // bit 4 additionally inhibits the bank 01 copies
  assign shadowed =
    (bank == `IIGS_BANK_SLOW0) || (bank == `IIGS_BANK_SLOW1) ||
    ((b0 || b1) && shadow[6] && hi_area) ||
    (b0 && !shadow[0] && txt1) ||
    (b1 && !shadow[0] && !shadow[4] && txt1) ||
    (b0 && !shadow[5] && txt2) ||
    (b1 && !shadow[5] && !shadow[4] && txt2) ||
    (b0 && (!shadow[1] || !shadow[3]) && hgr1) ||
    (b1 && ((!shadow[1] && !shadow[4]) || !shadow[3]) && hgr1) ||
    (b0 && (!shadow[2] || !shadow[3]) && hgr2) ||
    (b1 && ((!shadow[2] && !shadow[4]) || !shadow[3]) && hgr2);

  assign slowram_ce = shadowed && !io;

  assign romc_ce = (bank == `IIGS_BANK_ROMC);
  assign romd_ce = (bank == `IIGS_BANK_ROMD);
  assign rom1_ce = (bank == `IIGS_BANK_ROM1);

  // the vector pull always sees rom in bank 00
  assign rom2_ce = (bank == `IIGS_BANK_ROM2) ||
                   (b0 && hi_area && (rd_rom || !cpu_vpb));

  // with lc_we set, bank 00 D000 and up writes through to fast ram
  assign rom_writethrough = (cpu_addr.bank == `IIGS_BANK_MAIN0) &&
                            (cpu_addr.offset >= `IIGS_LC_BASE) && lc_we;

  assign fastram_ce = (cpu_addr.bank < `IIGS_RAM_BANKS) &&
                      (!rom2_ce || rom_writethrough) && !rom1_ce && !io;

  assign cpu_din = io ? io_dout : din;

endmodule

/* soft_switches/soft_switches.sv */
`timescale 1ns/1ps
`include "iigs_macros.svh"

module soft_switches import iigs_pkg::*; (
  input  logic       clk_sys,
  input  logic       cpu_vda,
  input  logic       cpu_ce,
  input  logic       cpu_we,
  input  logic       io,
  input  offset_t    addr,
  input  byte_t      cpu_dout,
  input  byte_t      vgc_int,
  input  byte_t      int_en,
  input  byte_t      int_flag,
  output byte_t      io_dout,
  output byte_t      shadow,
  output byte_t      text_color,
  output logic [3:0] border_color,
  output byte_t      new_video,
  output byte_t      slot_rom_sel,
  output logic       text_g,
  output logic       mix_g,
  output logic       page2,
  output logic       hires_mode,
  output logic       alt_charset,
  output logic       eighty_col,
  output logic       int_cx_rom,
  output logic       rd_rom,
  output logic       lc_ram2,
  output logic       lc_we,
  output logic       alt_zp,
  output logic       store80,
  output logic       ram_rd,
  output logic       ram_wrt,
  output logic       vgc_en_wr,
  output logic       vgc_clr_wr,
  output logic       inten_wr,
  output logic       int_clr
);

  logic  acc_stb;
  logic  wr_stb;
  logic  rd_stb;
  logic  pair_sel;
  logic  video_sel;
  logic  lc_sel;
  logic  lc_we_pre;
  logic  slot_c3rom;
  logic  status_bit;
  byte_t rd_data;

  assign acc_stb = cpu_ce && io;
  assign wr_stb  = acc_stb && cpu_we;
  assign rd_stb  = acc_stb && !cpu_we;

  // C000-C00F on writes, C002-C005 also on reads
  assign pair_sel = (addr[7:4] == 4'h0) &&
                    (wr_stb || (rd_stb && (addr[3:1] == 3'd1 || addr[3:1] == 3'd2)));
  assign video_sel = acc_stb && (addr[7:3] == 5'b01010);
  assign lc_sel    = acc_stb && (addr[7:4] == 4'h8);

  // strobes to the interrupt block, data rides on cpu_dout
  assign vgc_en_wr  = wr_stb && (addr[7:0] == `IIGS_OFS_VGCINT);
  assign vgc_clr_wr = wr_stb && (addr[7:0] == `IIGS_OFS_VGCINTCLR);
  assign inten_wr   = wr_stb && (addr[7:0] == `IIGS_OFS_INTEN);
  assign int_clr    = acc_stb && (addr[7:0] == `IIGS_OFS_INTCLR);

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      shadow       <= `IIGS_RST_SHADOW;
      new_video    <= `IIGS_RST_NEWVIDEO;
      text_color   <= `IIGS_RST_TEXTCOLOR;
      border_color <= 4'h0;
      slot_rom_sel <= 8'h00;
      text_g       <= 1'b0;
      mix_g        <= 1'b0;
      page2        <= 1'b0;
      hires_mode   <= 1'b0;
      alt_charset  <= 1'b0;
      eighty_col   <= 1'b0;
      int_cx_rom   <= 1'b0;
      slot_c3rom   <= 1'b0;
      alt_zp       <= 1'b0;
      store80      <= 1'b0;
      ram_rd       <= 1'b0;
      ram_wrt      <= 1'b0;
      rd_rom       <= 1'b1;
      lc_ram2      <= 1'b0;
      lc_we        <= 1'b0;
      lc_we_pre    <= 1'b0;
      io_dout      <= 8'h00;
    end else begin
      if (wr_stb) begin
        case (addr[7:0])
          `IIGS_OFS_TEXTCOLOR: text_color <= cpu_dout;
          `IIGS_OFS_NEWVIDEO:  new_video <= cpu_dout;
          `IIGS_OFS_SLTROMSEL: slot_rom_sel <= cpu_dout;
          `IIGS_OFS_BORDER:    border_color <= cpu_dout[3:0];
          `IIGS_OFS_SHADOW:    shadow <= cpu_dout;
          `IIGS_OFS_STATEREG: begin
            // bit 1 is reserved and reads back as 0
            {alt_zp, page2, ram_rd, ram_wrt, rd_rom, lc_ram2} <= cpu_dout[7:2];
            int_cx_rom <= cpu_dout[0];
          end
          default: ;
        endcase
      end

      // even offset clears, odd offset sets
      if (pair_sel) begin
        case (addr[3:1])
          3'd0: store80 <= addr[0];
          3'd1: ram_rd <= addr[0];
          3'd2: ram_wrt <= addr[0];
          3'd3: int_cx_rom <= addr[0];
          3'd4: alt_zp <= addr[0];
          3'd5: slot_c3rom <= addr[0];
          3'd6: eighty_col <= addr[0];
          default: alt_charset <= addr[0];
        endcase
      end

      if (video_sel) begin
        case (addr[2:1])
          2'd0: text_g <= addr[0];
          2'd1: mix_g <= addr[0];
          2'd2: page2 <= addr[0];
          default: hires_mode <= addr[0];
        endcase
      end

      // language card, two odd reads in a row unlock writes
      if (lc_sel) begin
        rd_rom  <= addr[0] ^ addr[1];
        lc_ram2 <= !addr[3];
        if (!cpu_we && addr[0]) begin
          lc_we     <= lc_we_pre;
          lc_we_pre <= 1'b1;
        end else begin
          lc_we     <= 1'b0;
          lc_we_pre <= 1'b0;
        end
      end

      if (rd_stb) begin
        io_dout <= rd_data;
      end
    end
  end

  // C011-C01F status in bit 7, C012 reports language card ram read
  always_comb begin
    case (addr[3:0])
      4'h1:    status_bit = lc_ram2;
      4'h2:    status_bit = !rd_rom;
      4'h3:    status_bit = ram_rd;
      4'h4:    status_bit = ram_wrt;
      4'h5:    status_bit = int_cx_rom;
      4'h6:    status_bit = alt_zp;
      4'h7:    status_bit = slot_c3rom;
      4'h8:    status_bit = store80;
      4'hA:    status_bit = text_g;
      4'hB:    status_bit = mix_g;
      4'hC:    status_bit = page2;
      4'hD:    status_bit = !hires_mode;
      4'hE:    status_bit = alt_charset;
      4'hF:    status_bit = eighty_col;
      default: status_bit = 1'b0;
    endcase
  end

  always_comb begin
    case (addr[7:0])
      `IIGS_OFS_TEXTCOLOR: rd_data = text_color;
      `IIGS_OFS_VGCINT:    rd_data = vgc_int;
      `IIGS_OFS_NEWVIDEO:  rd_data = new_video;
      `IIGS_OFS_SLTROMSEL: rd_data = slot_rom_sel;
      `IIGS_OFS_SHADOW:    rd_data = shadow;
      `IIGS_OFS_INTEN:     rd_data = int_en;
      `IIGS_OFS_INTFLAG:   rd_data = int_flag;
      `IIGS_OFS_STATEREG:
        rd_data = {alt_zp, page2, ram_rd, ram_wrt, rd_rom, lc_ram2, 1'b0, int_cx_rom};
      default:
        rd_data = (addr[7:4] == 4'h1) ? {status_bit, 7'd0} : 8'h00;
    endcase
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_sys,
  output logic cpu_vda
);

  initial begin
    clk_sys = 1'b0;
    forever #(PERIOD / 2) clk_sys = ~clk_sys;
  end

  // release reset away from the active edge
  initial begin
    cpu_vda = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_sys);
    @(negedge clk_sys);
    cpu_vda = 1'b0;
  end

endmodule

/* tests/tb_iigs_glue.sv */
`timescale 1ns/1ps

module tb_iigs_glue;

  localparam int          CLK_PERIOD = 100;
  localparam int          N_TRANS    = 600;
  localparam logic [31:0] SEED       = 32'h2dc9fb99;

  logic        clk_sys, cpu_vda, cpu_we, cpu_ce, cpu_vpb;
  logic [23:0] cpu_addr;
  logic [7:0]  cpu_dout, din;
  logic        scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq;
  logic [7:0]  bank, cpu_din, shadow, text_color, new_video, slot_rom_sel;
  logic [15:0] addr;
  logic [3:0]  border_color;
  logic        io, inhibit_cxxx, slowram_ce, fastram_ce, rom1_ce, rom2_ce, romc_ce, romd_ce;
  logic        irq_n, text_g, mix_g, page2, hires_mode, alt_charset, eighty_col;
  logic        int_cx_rom, rd_rom, lc_ram2, lc_we;

  // switch state as the testbench expects it
  logic       m_store80, m_ram_rd, m_ram_wrt, m_icx, m_alt_zp, m_c3rom, m_eighty, m_altchar;
  logic       m_text_g, m_mix_g, m_page2, m_hires, m_rd_rom, m_lc_ram2, m_lc_we, m_lc_pre;
  logic       m_irq_n;
  logic [7:0] m_shadow, m_text_color, m_new_video, m_slot;
  logic [3:0] m_border;

  logic        checks_on, rd_chk;
  logic [7:0]  exp_din;
  logic [25:0] exp_map;
  logic [5:0]  exp_ce;
  int          seed_val;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(16)) tb_clock_inst (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda)
  );

  iigs_glue iigs_glue_inst (
    .clk_sys(clk_sys), .cpu_vda(cpu_vda), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
    .cpu_we(cpu_we), .cpu_ce(cpu_ce), .cpu_vpb(cpu_vpb), .din(din),
    .scanline_irq(scanline_irq), .vbl_irq(vbl_irq), .onesecond_irq(onesecond_irq),
    .qtrsecond_irq(qtrsecond_irq), .bank(bank), .addr(addr), .cpu_din(cpu_din),
    .io(io), .inhibit_cxxx(inhibit_cxxx), .slowram_ce(slowram_ce),
    .fastram_ce(fastram_ce), .rom1_ce(rom1_ce), .rom2_ce(rom2_ce), .romc_ce(romc_ce),
    .romd_ce(romd_ce), .irq_n(irq_n), .shadow(shadow), .text_color(text_color),
    .border_color(border_color), .new_video(new_video), .slot_rom_sel(slot_rom_sel),
    .text_g(text_g), .mix_g(mix_g), .page2(page2), .hires_mode(hires_mode),
    .alt_charset(alt_charset), .eighty_col(eighty_col), .int_cx_rom(int_cx_rom),
    .rd_rom(rd_rom), .lc_ram2(lc_ram2), .lc_we(lc_we)
  );

  // result is {io, inhibit_cxxx, bank, addr}
  function automatic logic [25:0] ref_map(input logic [23:0] a, input logic we);
    logic [7:0]  b;
    logic [7:0]  pg;
    logic        rw, sel, aux, main_b, slow_b, lc, slot, io_r;
    b      = a[23:16];
    pg     = a[15:8];
    rw     = we ? m_ram_wrt : m_ram_rd;
    main_b = (b == 8'h00) || (b == 8'h01);
    slow_b = (b == 8'hE0) || (b == 8'hE1);
    if (pg <= 8'h01 || pg >= 8'hC0)
      sel = m_alt_zp;
    else if (pg >= 8'h04 && pg <= 8'h07)
      sel = m_store80 ? m_page2 : rw;
    else if (pg >= 8'h20 && pg <= 8'h3F)
      sel = (m_store80 && m_hires) ? m_page2 : rw;
    else
      sel = rw;
    aux  = sel && (b == 8'h00 || b == 8'hE0);
    lc   = (pg >= 8'hD0 && pg <= 8'hDF) && m_lc_ram2 &&
           ((slow_b && m_rd_rom) || (main_b && !m_shadow[6]));
    slot = (a[7:0] >= 8'h90) && m_slot[a[6:4]];
    io_r = (main_b || slow_b) && !m_shadow[6] && pg == 8'hC0 && !slot;
    return {io_r, lc || (main_b && m_shadow[6]), b + {7'd0, aux},
            lc ? a[15:0] - 16'h1000 : a[15:0]};
  endfunction

  // result is {slowram, fastram, rom1, rom2, romc, romd}
  function automatic logic [5:0] ref_ce(input logic [25:0] m, input logic [23:0] a,
                                        input logic vpb);
    logic [7:0]  mb;
    logic [15:0] ma;
    logic        b0, b1, aux_ok, t1, t2, h1, h2, region, slow, rom2, wt, fast;
    mb     = m[23:16];
    ma     = m[15:0];
    b0     = mb == 8'h00;
    b1     = mb == 8'h01;
    aux_ok = b0 || (b1 && !m_shadow[4]);
    t1     = ma >= 16'h0400 && ma <= 16'h07FF;
    t2     = ma >= 16'h0800 && ma <= 16'h0BFF;
    h1     = ma >= 16'h2000 && ma <= 16'h3FFF;
    h2     = ma >= 16'h4000 && ma <= 16'h5FFF;
    // super hi-res shadowing reaches both banks
    region = aux_ok && ((t1 && !m_shadow[0]) || (t2 && !m_shadow[5]) ||
                        (h1 && !m_shadow[1]) || (h2 && !m_shadow[2]));
    region = region || ((b0 || b1) && !m_shadow[3] && (h1 || h2));
    slow   = (mb == 8'hE0 || mb == 8'hE1 || ((b0 || b1) && m_shadow[6] && ma >= 16'hC000) ||
              region) && !m[25];
    rom2   = mb == 8'hFF || (b0 && ma >= 16'hC000 && (m_rd_rom || !vpb));
    wt     = a[23:16] == 8'h00 && a[15:0] >= 16'hD000 && m_lc_we;
    fast   = a[23:16] < 8'd20 && (!rom2 || wt) && mb != 8'hFE && !m[25];
    return {slow, fast, mb == 8'hFE, rom2, mb == 8'hFC, mb == 8'hFD};
  endfunction

  function automatic logic [7:0] ref_read(input logic [7:0] ofs);
    logic st;
    case (ofs[3:0])
      4'h1: st = m_lc_ram2;
      4'h2: st = !m_rd_rom;
      4'h3: st = m_ram_rd;
      4'h4: st = m_ram_wrt;
      4'h5: st = m_icx;
      4'h6: st = m_alt_zp;
      4'h7: st = m_c3rom;
      4'h8: st = m_store80;
      4'hA: st = m_text_g;
      4'hB: st = m_mix_g;
      4'hC: st = m_page2;
      4'hD: st = !m_hires;
      4'hE: st = m_altchar;
      4'hF: st = m_eighty;
      default: st = 1'b0;
    endcase
    case (ofs)
      8'h22: return m_text_color;
      8'h29: return m_new_video;
      8'h2D: return m_slot;
      8'h35: return m_shadow;
      8'h68: return {m_alt_zp, m_page2, m_ram_rd, m_ram_wrt, m_rd_rom, m_lc_ram2, 1'b0, m_icx};
      default: return (ofs[7:4] == 4'h1) ? {st, 7'd0} : 8'h00;
    endcase
  endfunction

  // applies one I/O access to the expected switch state
  task automatic model_access(input logic [7:0] ofs, input logic we, input logic [7:0] d);
    if (we) begin
      case (ofs)
        8'h22: m_text_color = d;
        8'h29: m_new_video = d;
        8'h2D: m_slot = d;
        8'h34: m_border = d[3:0];
        8'h35: m_shadow = d;
        8'h68: begin
          {m_alt_zp, m_page2, m_ram_rd, m_ram_wrt, m_rd_rom, m_lc_ram2} = d[7:2];
          m_icx = d[0];
        end
        default: ;
      endcase
    end
    if (ofs[7:4] == 4'h0 && (we || (ofs[3:0] >= 4'h2 && ofs[3:0] <= 4'h5))) begin
      case (ofs[3:0] & 4'hE)
        4'h0: m_store80 = ofs[0];
        4'h2: m_ram_rd = ofs[0];
        4'h4: m_ram_wrt = ofs[0];
        4'h6: m_icx = ofs[0];
        4'h8: m_alt_zp = ofs[0];
        4'hA: m_c3rom = ofs[0];
        4'hC: m_eighty = ofs[0];
        default: m_altchar = ofs[0];
      endcase
    end
    case (ofs & 8'hFE)
      8'h50: m_text_g = ofs[0];
      8'h52: m_mix_g = ofs[0];
      8'h54: m_page2 = ofs[0];
      8'h56: m_hires = ofs[0];
      default: ;
    endcase
    if (ofs[7:4] == 4'h8) begin
      m_rd_rom  = ofs[0] ^ ofs[1];
      m_lc_ram2 = !ofs[3];
      if (!we && ofs[0]) begin
        m_lc_we  = m_lc_pre;
        m_lc_pre = 1'b1;
      end else begin
        m_lc_we  = 1'b0;
        m_lc_pre = 1'b0;
      end
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    $display("sim failed");
    $fatal(1, "stopping on first mismatch");
  endtask

  // every task below starts and ends on a falling edge
  task automatic io_write(input logic [7:0] ofs, input logic [7:0] d);
    cpu_addr = {16'h00C0, ofs};
    cpu_we   = 1'b1;
    cpu_dout = d;
    cpu_ce   = 1'b1;
    @(negedge clk_sys);
    cpu_ce = 1'b0;
    cpu_we = 1'b0;
    model_access(ofs, 1'b1, d);
  endtask

  task automatic io_read(input logic [7:0] ofs, input logic [7:0] exp);
    cpu_addr = {16'h00C0, ofs};
    cpu_we   = 1'b0;
    cpu_ce   = 1'b1;
    @(negedge clk_sys);
    cpu_ce = 1'b0;
    model_access(ofs, 1'b0, 8'h00);
    exp_din = exp;
    rd_chk  = 1'b1;
    @(negedge clk_sys);
    rd_chk = 1'b0;
  endtask

  task automatic apply_random_addr();
    logic [7:0] b;
    case ($urandom_range(0, 5))
      0: b = 8'h00;
      1: b = 8'h01;
      2: b = 8'hE0;
      3: b = 8'hE1;
      4: b = 8'hFC + 8'($urandom_range(0, 3));
      default: b = 8'($urandom_range(0, 255));
    endcase
    cpu_addr = {b, 16'($urandom_range(0, 65535))};
    // bias towards the language card window
    if ($urandom_range(0, 2) == 0) cpu_addr[15:12] = 4'hD;
    cpu_we  = 1'($urandom_range(0, 1));
    cpu_vpb = 1'($urandom_range(0, 1));
    din     = 8'($urandom_range(0, 255));
    @(negedge clk_sys);
  endtask

  always @(posedge clk_sys) begin
    if (checks_on) begin
      exp_map = ref_map(cpu_addr, cpu_we);
      exp_ce  = ref_ce(exp_map, cpu_addr, cpu_vpb);
      assert ({io, inhibit_cxxx, bank, addr} == exp_map)
        else report_mismatch("io/inhibit/bank/addr", {io, inhibit_cxxx, bank, addr}, exp_map);
      assert ({slowram_ce, fastram_ce, rom1_ce, rom2_ce, romc_ce, romd_ce} == exp_ce)
        else report_mismatch("chip enables",
                             {slowram_ce, fastram_ce, rom1_ce, rom2_ce, romc_ce, romd_ce},
                             exp_ce);
      assert ({text_g, mix_g, page2, hires_mode, alt_charset, eighty_col, int_cx_rom,
               rd_rom, lc_ram2, lc_we} ==
              {m_text_g, m_mix_g, m_page2, m_hires, m_altchar, m_eighty, m_icx,
               m_rd_rom, m_lc_ram2, m_lc_we})
        else report_mismatch("switch ports",
                             {text_g, mix_g, page2, hires_mode, alt_charset, eighty_col,
                              int_cx_rom, rd_rom, lc_ram2, lc_we},
                             {m_text_g, m_mix_g, m_page2, m_hires, m_altchar, m_eighty,
                              m_icx, m_rd_rom, m_lc_ram2, m_lc_we});
      assert ({text_color, new_video, slot_rom_sel, border_color} ==
              {m_text_color, m_new_video, m_slot, m_border})
        else report_mismatch("video registers",
                             {text_color, new_video, slot_rom_sel, border_color},
                             {m_text_color, m_new_video, m_slot, m_border});
      assert (shadow == m_shadow) else report_mismatch("shadow", shadow, m_shadow);
      assert (irq_n == m_irq_n) else report_mismatch("irq_n", irq_n, m_irq_n);
      if (rd_chk) begin
        assert (cpu_din == exp_din) else report_mismatch("read data", cpu_din, exp_din);
      end else if (!exp_map[25]) begin
        assert (cpu_din == din) else report_mismatch("memory read data", cpu_din, din);
      end
    end
  end

  initial begin
    #(4 * N_TRANS * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin
    seed_val = $urandom(SEED);
    cpu_addr = 24'h000000;
    cpu_dout = 8'h00;
    cpu_we = 1'b0;
    cpu_ce = 1'b0;
    cpu_vpb = 1'b1;
    din = 8'h5A;
    {scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq} = 4'b0000;
    {m_store80, m_ram_rd, m_ram_wrt, m_icx, m_alt_zp, m_c3rom, m_eighty, m_altchar} = 8'h00;
    {m_text_g, m_mix_g, m_page2, m_hires, m_lc_ram2, m_lc_we, m_lc_pre} = 7'd0;
    m_rd_rom = 1'b1;
    m_irq_n = 1'b1;
    m_shadow = 8'h08;
    m_new_video = 8'h41;
    m_text_color = 8'hF2;
    m_slot = 8'h00;
    m_border = 4'h0;
    checks_on = 1'b0;
    rd_chk = 1'b0;
    exp_din = 8'h00;
    @(negedge cpu_vda);
    @(negedge clk_sys);
    checks_on = 1'b1;

    // reset values
    io_read(8'h35, 8'h08);
    io_read(8'h29, 8'h41);
    io_read(8'h22, 8'hF2);
    io_read(8'h68, 8'h08);

    // video registers
    io_write(8'h22, 8'($urandom_range(0, 255)));
    io_write(8'h29, 8'($urandom_range(0, 255)));
    io_write(8'h34, 8'($urandom_range(0, 255)));
    io_read(8'h22, m_text_color);
    io_read(8'h29, m_new_video);

    // switch round trip
    repeat (40) begin
      case ($urandom_range(0, 2))
        0: io_write(8'($urandom_range(0, 15)), 8'($urandom_range(0, 255)));
        1: io_write(8'h50 + 8'($urandom_range(0, 7)), 8'h00);
        default: io_read(8'h50 + 8'($urandom_range(0, 7)), 8'h00);
      endcase
    end
    for (int ofs = 8'h11; ofs <= 8'h1F; ofs++) begin
      io_read(8'(ofs), ref_read(8'(ofs)));
    end

    // address remap
    repeat (8) begin
      io_write(8'h2D, 8'($urandom_range(0, 255)));
      io_write(8'h68, 8'($urandom_range(0, 255)));
      io_write(8'($urandom_range(0, 1)), 8'h00);
      io_write(8'h56 + 8'($urandom_range(0, 1)), 8'h00);
      io_read(8'h80 + 8'($urandom_range(0, 15)), 8'h00);
      repeat (20) apply_random_addr();
    end

    // shadow bit 6 stays clear here so the I/O page stays reachable
    repeat (8) begin
      io_write(8'h35, 8'($urandom_range(0, 255)) & 8'hBF);
      repeat (20) apply_random_addr();
    end
    cpu_vpb = 1'b1;

    // language card write enable
    io_read(8'h80, 8'h00);
    io_read(8'h81, 8'h00);
    io_read(8'h81, 8'h00);
    io_read(8'h80, 8'h00);
    io_read(8'h81, 8'h00);
    io_write(8'h81, 8'h00);
    io_read(8'h81, 8'h00);
    io_read(8'h81, 8'h00);
    io_read(8'h80, 8'h00);

    // interrupts
    io_write(8'h23, 8'h02);
    scanline_irq = 1'b1;
    @(negedge clk_sys);
    scanline_irq = 1'b0;
    m_irq_n = 1'b0;
    io_read(8'h23, 8'hA2);
    io_write(8'h32, 8'h00);
    m_irq_n = 1'b1;
    io_write(8'h41, 8'h08);
    vbl_irq = 1'b1;
    @(negedge clk_sys);
    vbl_irq = 1'b0;
    m_irq_n = 1'b0;
    @(negedge clk_sys);
    io_read(8'h46, 8'h09);
    io_write(8'h47, 8'h00);
    m_irq_n = 1'b1;
    io_read(8'h46, 8'h00);

    // shadow bit 6 takes the I/O page away for the rest of the run
    io_write(8'h35, 8'($urandom_range(0, 255)) | 8'h40);
    repeat (20) apply_random_addr();

    $display("sim passed");
    $finish;
  end

endmodule
